//--- Bender.yml
package:
  name: ofm_out

sources:
  - include_dirs:
      - common
    files:
      - common/ofm_pkg.sv
      - pool/pool_line_fifo.sv
      - pool/pool_stage.sv
      - verilog/relu_stage.sv
      - verilog/ofm_writer.sv
      - verilog/ofm_top.sv
  - target: test
    include_dirs:
      - common
      - test
    files:
      - test/tb_ofm_top.sv

//--- common/ofm_pkg.sv
`include "ofm_settings.svh"

package ofm_pkg;

	typedef logic signed [`OFM_DATA_WIDTH - 1 : 0] lane_t;

	typedef logic [`OFM_ADDR_WIDTH - 1 : 0] ofm_addr_t;

	// Holds 1 to POOL_FIFO_DEPTH.
	typedef logic [$clog2(`POOL_FIFO_DEPTH + 1) - 1 : 0] word_count_t;

	// **************************************************
	// One result row word, seen as lanes or lane pairs
	// **************************************************
	typedef union packed {
		lane_t [`OFM_LANES - 1 : 0]            lanes; // Stride 1, bypass, ReLU.
		lane_t [`OFM_LANES / 2 - 1 : 0][1 : 0] pairs; // Stride 2 pooling.
	} row_word_u;

endpackage

//--- common/ofm_settings.svh
`ifndef OFM_SETTINGS_SVH
`define OFM_SETTINGS_SVH

// **************************************************
// Row word geometry
// **************************************************
`define OFM_LANES 16
`define OFM_DATA_WIDTH 16

// **************************************************
// Output memory and pooling
// **************************************************
`define OFM_ADDR_WIDTH 22
`define POOL_FIFO_DEPTH 16

// A factor of 0 on negative lanes gives plain ReLU.
`define RELU_NEG_SCALE 0

`endif

//--- filelist.f
+incdir+common
+incdir+test
common/ofm_pkg.sv
pool/pool_line_fifo.sv
pool/pool_stage.sv
verilog/relu_stage.sv
verilog/ofm_writer.sv
verilog/ofm_top.sv
test/tb_ofm_top.sv

//--- pool/pool_line_fifo.sv
`timescale 1ns/1ps
`include "ofm_settings.svh"

module pool_line_fifo (
	input  logic             clk  ,
	input  logic             rst  ,
	input  logic             clr  ,
	input  logic             push ,
	input  logic             pop  ,
	input  ofm_pkg::row_word_u din  ,
	output ofm_pkg::row_word_u dout
);

	import ofm_pkg::*;

	localparam int PTR_W = $clog2(`POOL_FIFO_DEPTH);

	row_word_u          mem [`POOL_FIFO_DEPTH];
	logic [PTR_W - 1 : 0] wr_ptr;
	logic [PTR_W - 1 : 0] rd_ptr;

	function automatic logic [PTR_W - 1 : 0] ptr_next(input logic [PTR_W - 1 : 0] p);
		return (p == PTR_W'(`POOL_FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (rst || clr) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= din;
	end

	assign dout = mem[rd_ptr]; // Head word is usable by a pop this cycle.

endmodule

//--- pool/pool_stage.sv
`timescale 1ns/1ps
`include "ofm_settings.svh"

module pool_stage (
	input  logic                 clk            ,
	input  logic                 rst            ,
	input  logic                 start          ,
	input  logic                 maxpool_mode   ,
	input  logic [1 : 0]         maxpool_stride ,
	input  ofm_pkg::word_count_t words_per_row  ,
	input  logic                 row_valid      ,
	input  ofm_pkg::row_word_u   row_data       ,
	input  logic                 row_last       ,
	output logic                 pool_valid     ,
	output ofm_pkg::row_word_u   pool_data      ,
	output logic                 pool_last
);

	import ofm_pkg::*;

	word_count_t word_cnt;
	logic        row_odd;
	logic        first_row;
	logic        row_end;
	logic        stride_one;
	logic        push;
	logic        pop;
	logic        out_en;
	row_word_u   h_word;
	row_word_u   v_word;
	row_word_u   fifo_dout;

	function automatic lane_t lane_max(input lane_t a, input lane_t b);
		return (a > b) ? a : b;
	endfunction

	assign stride_one = (maxpool_stride == 2'd1);
	assign row_end    = (word_cnt == words_per_row - 5'd1);

	always_ff @(posedge clk) begin
		if (rst || start) begin
			word_cnt  <= '0;
			row_odd   <= 1'b0;
			first_row <= 1'b1;
		end else if (row_valid) begin
			if (row_end) begin
				word_cnt  <= '0;
				row_odd   <= ~row_odd;
				first_row <= 1'b0;
			end else begin
				word_cnt <= word_cnt + 5'd1;
			end
		end
	end

	// **************************************************
	// Horizontal max, then vertical max against the row FIFO
	// **************************************************
	always_comb begin
		h_word = '0; // High half stays zero at stride 2.
		if (stride_one) begin
			for (int i = 0; i < `OFM_LANES - 1; i++)
				h_word.lanes[i] = lane_max(row_data.lanes[i], row_data.lanes[i + 1]);
			h_word.lanes[`OFM_LANES - 1] = row_data.lanes[`OFM_LANES - 1]; // Edge lane.
		end else begin
			for (int j = 0; j < `OFM_LANES / 2; j++)
				h_word.lanes[j] = lane_max(row_data.pairs[j][0], row_data.pairs[j][1]);
		end
	end

	always_comb begin
		for (int i = 0; i < `OFM_LANES; i++)
			v_word.lanes[i] = lane_max(h_word.lanes[i], fifo_dout.lanes[i]);
	end

	assign push   = row_valid && maxpool_mode && (stride_one || !row_odd);
	assign pop    = row_valid && maxpool_mode && (stride_one ? !first_row : row_odd);
	assign out_en = maxpool_mode ? pop : row_valid;

	pool_line_fifo u_pool_line_fifo (
		.clk  ( clk       ),
		.rst  ( rst       ),
		.clr  ( start     ),
		.push ( push      ),
		.pop  ( pop       ),
		.din  ( h_word    ),
		.dout ( fifo_dout )
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			pool_valid <= 1'b0;
			pool_last  <= 1'b0;
		end else begin
			pool_valid <= out_en;
			pool_last  <= out_en && row_last;
		end
	end

	always_ff @(posedge clk) begin
		if (out_en)
			pool_data <= maxpool_mode ? v_word : row_data; // Bypass when off.
	end

endmodule

//--- test/tb_ofm_model.svh
`ifndef TB_OFM_MODEL_SVH
`define TB_OFM_MODEL_SVH

function automatic lane_t bigger_lane(input lane_t a, input lane_t b);
	return (b > a) ? b : a;
endfunction

// **************************************************
// Expected pooled word for input word k of the frame
// **************************************************
function automatic row_word_u pooled_word(input int k, input bit stride_one, input int wpr);
	row_word_u cur;
	row_word_u up;
	row_word_u res;
	lane_t     m;
	cur = frame_words[k];
	up  = frame_words[k - wpr]; // Same column, row above.
	res = '0;
	if (stride_one) begin
		for (int i = 0; i < `OFM_LANES; i++) begin
			m = bigger_lane(cur.lanes[i], up.lanes[i]);
			if (i < `OFM_LANES - 1) begin
				m = bigger_lane(m, cur.lanes[i + 1]);
				m = bigger_lane(m, up.lanes[i + 1]);
			end
			res.lanes[i] = m;
		end
	end else begin
		for (int j = 0; j < `OFM_LANES / 2; j++) begin
			m = bigger_lane(cur.lanes[2 * j], cur.lanes[2 * j + 1]);
			res.lanes[j] = bigger_lane(m, bigger_lane(up.lanes[2 * j], up.lanes[2 * j + 1]));
		end
	end
	return res;
endfunction

function automatic row_word_u leaky_relu_word(input row_word_u w);
	row_word_u res;
	int        p;
	for (int i = 0; i < `OFM_LANES; i++) begin
		p = int'(w.lanes[i]) * `RELU_NEG_SCALE;
		res.lanes[i] = (w.lanes[i] < 0) ? p[`OFM_DATA_WIDTH - 1 : 0] : w.lanes[i];
	end
	return res;
endfunction

task automatic build_expected(input bit mode, input logic [1 : 0] stride, input int wpr,
	input ofm_addr_t base, input int src0);
	ofm_addr_t addr;
	int        row;
	bit        keep;
	row_word_u w;
	addr = base;
	for (int k = 0; k < frame_words.size(); k++) begin
		row = k / wpr;
		if (!mode)
			keep = 1'b1;
		else if (stride == 2'd1)
			keep = (row > 0);
		else
			keep = (row % 2 == 1);
		if (keep) begin
			w = mode ? pooled_word(k, stride == 2'd1, wpr) : frame_words[k];
			exp_data.push_back(leaky_relu_word(w));
			exp_addr.push_back(addr);
			exp_done.push_back(k == frame_words.size() - 1);
			exp_src.push_back(src0 + k);
			addr = addr + 1'b1;
		end
	end
endtask

`endif

//--- test/tb_ofm_top.sv
`timescale 1ns/1ps
`include "ofm_settings.svh"

module tb_ofm_top;

	import ofm_pkg::*;

	localparam bit [31:0] LFSR_SEED     = 32'h6bdc_a761;
	localparam int        DRAIN_TIMEOUT = 400;

	logic         clk;
	logic         rst;
	logic         start;
	logic         maxpool_mode;
	logic [1 : 0] maxpool_stride;
	word_count_t  words_per_row;
	ofm_addr_t    start_write_addr;
	logic         row_valid;
	row_word_u    row_data;
	logic         row_last;
	logic         ofm_we;
	ofm_addr_t    ofm_addr;
	row_word_u    ofm_data;
	logic         done;

	bit [31:0] lfsr_state;
	row_word_u frame_words[$];
	row_word_u exp_data[$];
	ofm_addr_t exp_addr[$];
	bit        exp_done[$];
	int        exp_src[$];  // Global index of the input word.
	int        in_cyc[$];   // Cycle of each input word.
	int        cyc;
	int        in_count;
	int        frame_cnt;
	int        done_cnt;

	`include "tb_ofm_model.svh"

	ofm_top u_ofm_top (
		.clk              ( clk              ),
		.rst              ( rst              ),
		.start            ( start            ),
		.maxpool_mode     ( maxpool_mode     ),
		.maxpool_stride   ( maxpool_stride   ),
		.words_per_row    ( words_per_row    ),
		.start_write_addr ( start_write_addr ),
		.row_valid        ( row_valid        ),
		.row_data         ( row_data         ),
		.row_last         ( row_last         ),
		.ofm_we           ( ofm_we           ),
		.ofm_addr         ( ofm_addr         ),
		.ofm_data         ( ofm_data         ),
		.done             ( done             )
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic bit [31:0] lfsr_next(input bit [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic bit [31:0] rand_bits(input int n);
		bit [31:0] v;
		v = '0;
		for (int b = 0; b < n; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic row_word_u random_word();
		row_word_u w;
		for (int i = 0; i < `OFM_LANES; i++)
			w.lanes[i] = lane_t'(rand_bits(`OFM_DATA_WIDTH));
		return w;
	endfunction

	// **************************************************
	// Error reporting and compare tasks
	// **************************************************
	task automatic report_mismatch(input string msg);
		$display("[ERROR] %0t ns: %s", $time, msg);
		$display("sim failed");
		$fatal(1, "stopping at first mismatch");
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: %s", what);
		$display("sim failed");
		$fatal(1, "stopping on timeout");
	endtask

	task automatic check_word(input row_word_u got, input row_word_u exp);
		if (got !== exp)
			report_mismatch($sformatf("data %h, expected %h", got, exp));
	endtask

	task automatic check_addr(input ofm_addr_t got, input ofm_addr_t exp);
		if (got !== exp)
			report_mismatch($sformatf("address %h, expected %h", got, exp));
	endtask

	task automatic check_done(input bit got, input bit exp);
		if (got !== exp)
			report_mismatch($sformatf("done %0b, expected %0b", got, exp));
	endtask

	task automatic check_cycle(input int got, input int exp);
		if (got != exp)
			report_mismatch($sformatf("write in cycle %0d, expected cycle %0d", got, exp));
	endtask

	// Outputs are stable at the falling edge.
	always @(negedge clk) begin
		cyc = cyc + 1;
		if (!rst) begin
			if (row_valid)
				in_cyc.push_back(cyc);
			if (ofm_we) begin
				if (exp_data.size() == 0)
					report_mismatch("write strobe with no word expected");
				check_cycle(cyc, in_cyc[exp_src[0]] + 3); // Three stages.
				check_addr(ofm_addr, exp_addr.pop_front());
				check_word(ofm_data, exp_data.pop_front());
				check_done(done, exp_done.pop_front());
				void'(exp_src.pop_front());
				if (done)
					done_cnt++;
			end else begin
				check_done(done, 1'b0);
			end
		end
	end

	task automatic wait_drained(input int frame_no);
		int t;
		t = 0;
		while (exp_data.size() != 0 || done_cnt != frame_no) begin
			if (t == DRAIN_TIMEOUT)
				report_timeout("the frame's output words and done pulse did not all arrive");
			t++;
			@(posedge clk);
		end
	endtask

	task automatic run_frame(input bit mode, input logic [1 : 0] stride, input int wpr,
		input int rows, input bit gaps);
		ofm_addr_t base;
		int        n;
		int        gap;
		base = ofm_addr_t'(rand_bits(`OFM_ADDR_WIDTH));
		n    = wpr * rows;
		frame_words.delete();
		for (int k = 0; k < n; k++)
			frame_words.push_back(random_word());
		build_expected(mode, stride, wpr, base, in_count);
		frame_cnt++;
		@(posedge clk);
		maxpool_mode     <= mode;
		maxpool_stride   <= stride;
		words_per_row    <= word_count_t'(wpr);
		start_write_addr <= base;
		start            <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		for (int k = 0; k < n; k++) begin
			gap = gaps ? int'(rand_bits(2)) : 0;
			repeat (gap) begin
				row_valid <= 1'b0;
				row_last  <= 1'b0;
				@(posedge clk);
			end
			row_valid <= 1'b1;
			row_data  <= frame_words[k];
			row_last  <= (k == n - 1);
			in_count++;
			@(posedge clk);
		end
		row_valid <= 1'b0;
		row_last  <= 1'b0;
		wait_drained(frame_cnt);
	endtask

	initial begin
		lfsr_state       = LFSR_SEED;
		cyc              = 0;
		in_count         = 0;
		frame_cnt        = 0;
		done_cnt         = 0;
		rst              = 1'b1;
		start            = 1'b0;
		maxpool_mode     = 1'b0;
		maxpool_stride   = 2'd1;
		words_per_row    = word_count_t'(1);
		start_write_addr = '0;
		row_valid        = 1'b0;
		row_data         = '0;
		row_last         = 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		run_frame(1'b0, 2'd1, int'(rand_bits(4)) + 1, 3, 1'b1); // Bypass.
		run_frame(1'b1, 2'd2, int'(rand_bits(4)) + 1, 4, 1'b1);
		run_frame(1'b1, 2'd1, int'(rand_bits(4)) + 1, 3, 1'b0); // Back to back rows.
		run_frame(1'b1, 2'd3, int'(rand_bits(4)) + 1, 2, 1'b1); // Restart at stride 2.
		run_frame(1'b1, 2'd1, `POOL_FIFO_DEPTH, 2, 1'b0);       // Full row FIFO.
		run_frame(1'b0, 2'd0, int'(rand_bits(4)) + 1, 2, 1'b1);
		if (exp_data.size() == 0 && done_cnt == frame_cnt)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- verilog/ofm_top.sv
`timescale 1ns/1ps

module ofm_top (
	input  logic                 clk              ,
	input  logic                 rst              ,
	input  logic                 start            ,
	input  logic                 maxpool_mode     ,
	input  logic [1 : 0]         maxpool_stride   ,
	input  ofm_pkg::word_count_t words_per_row    ,
	input  ofm_pkg::ofm_addr_t   start_write_addr ,
	input  logic                 row_valid        ,
	input  ofm_pkg::row_word_u   row_data         ,
	input  logic                 row_last         ,
	output logic                 ofm_we           ,
	output ofm_pkg::ofm_addr_t   ofm_addr         ,
	output ofm_pkg::row_word_u   ofm_data         ,
	output logic                 done
);

	import ofm_pkg::*;

	logic      pool_valid;
	row_word_u pool_data;
	logic      pool_last;

	logic      act_valid;
	row_word_u act_data;
	logic      act_last;

	pool_stage u_pool_stage (
		.clk            ( clk            ),
		.rst            ( rst            ),
		.start          ( start          ),
		.maxpool_mode   ( maxpool_mode   ),
		.maxpool_stride ( maxpool_stride ),
		.words_per_row  ( words_per_row  ),
		.row_valid      ( row_valid      ),
		.row_data       ( row_data       ),
		.row_last       ( row_last       ),
		.pool_valid     ( pool_valid     ),
		.pool_data      ( pool_data      ),
		.pool_last      ( pool_last      )
	);

	relu_stage u_relu_stage (
		.clk       ( clk        ),
		.rst       ( rst        ),
		.in_valid  ( pool_valid ),
		.in_data   ( pool_data  ),
		.in_last   ( pool_last  ),
		.out_valid ( act_valid  ),
		.out_data  ( act_data   ),
		.out_last  ( act_last   )
	);

	ofm_writer u_ofm_writer (
		.clk              ( clk              ),
		.rst              ( rst              ),
		.start            ( start            ),
		.start_write_addr ( start_write_addr ),
		.in_valid         ( act_valid        ),
		.in_data          ( act_data         ),
		.in_last          ( act_last         ),
		.ofm_we           ( ofm_we           ),
		.ofm_addr         ( ofm_addr         ),
		.ofm_data         ( ofm_data         ),
		.done             ( done             )
	);

endmodule

//--- verilog/ofm_writer.sv
`timescale 1ns/1ps

module ofm_writer (
	input  logic               clk              ,
	input  logic               rst              ,
	input  logic               start            ,
	input  ofm_pkg::ofm_addr_t start_write_addr ,
	input  logic               in_valid         ,
	input  ofm_pkg::row_word_u in_data          ,
	input  logic               in_last          ,
	output logic               ofm_we           ,
	output ofm_pkg::ofm_addr_t ofm_addr         ,
	output ofm_pkg::row_word_u ofm_data         ,
	output logic               done
);

	import ofm_pkg::*;

	ofm_addr_t addr_cnt; // Next free word.

	always_ff @(posedge clk) begin
		if (rst) begin
			addr_cnt <= '0;
		end else if (start) begin
			addr_cnt <= start_write_addr;
		end else if (in_valid) begin
			addr_cnt <= addr_cnt + 1'b1;
		end
	end

	// **************************************************
	// Write port and end of frame
	// **************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			ofm_we <= 1'b0;
			done   <= 1'b0;
		end else begin
			ofm_we <= in_valid;
			done   <= in_valid && in_last;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			ofm_addr <= addr_cnt;
			ofm_data <= in_data;
		end
	end

endmodule

//--- verilog/relu_stage.sv
`timescale 1ns/1ps
`include "ofm_settings.svh"

module relu_stage (
	input  logic               clk       ,
	input  logic               rst       ,
	input  logic               in_valid  ,
	input  ofm_pkg::row_word_u in_data   ,
	input  logic               in_last   ,
	output logic               out_valid ,
	output ofm_pkg::row_word_u out_data  ,
	output logic               out_last
);

	import ofm_pkg::*;

	row_word_u relu_word;

	always_comb begin
		for (int i = 0; i < `OFM_LANES; i++) begin
			if (in_data.lanes[i][`OFM_DATA_WIDTH - 1])
				relu_word.lanes[i] = lane_t'(in_data.lanes[i] * `RELU_NEG_SCALE); // Low bits.
			else
				relu_word.lanes[i] = in_data.lanes[i];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			out_last  <= 1'b0;
		end else begin
			out_valid <= in_valid;
			out_last  <= in_valid && in_last;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid)
			out_data <= relu_word;
	end

endmodule
